/* Makefile */
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module tb_ins_fetch \
		--Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
hw/ap_isa_pkg.sv
hw/ap_mem_pkg.sv
hw/ins_fetch_seq.sv
hw/ins_cache.sv
hw/isa_axil_reader.sv
hw/ins_fetch_top.sv
verification/tb_axil_mem.sv
verification/tb_ins_fetch.sv

/* hw/ap_isa_pkg.sv */
`default_nettype none

package ap_isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction word fields.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int OPCODE_W   = 4;
    localparam int CAM_ADDR_W = 8;
    localparam int OPERAND2_W = 2;
    localparam int MEM_ADDR_W = 16;
    localparam int INS_W      = OPCODE_W + CAM_ADDR_W + OPERAND2_W + MEM_ADDR_W;
    localparam int INS_ADDR_W = 16;

    // Unlisted codes are legal and pass through untouched.
    typedef enum logic [OPCODE_W-1:0] {
        RESET    = 4'd1,
        RET      = 4'd2,    // Ends a run.
        LOADRBR  = 4'd4,
        LOADCBC  = 4'd5,
        STORERBR = 4'd6,
        STORECBC = 4'd7,
        COPY     = 4'd8,
        ADD      = 4'd9,
        SUB      = 4'd10,
        TSC      = 4'd11,
        ABS      = 4'd12
    } opcode_e;

    typedef logic [CAM_ADDR_W-1:0] cam_addr_t;     // CAM row.
    typedef logic [OPERAND2_W-1:0] operand2_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;     // Data memory word.

    // Opcode sits in the top bits.
    typedef struct packed {
        opcode_e   op;
        cam_addr_t cam_addr;
        operand2_t operand2;
        mem_addr_t mem_addr;
    } ins_t;

    // Instruction memory is word addressed.
    typedef logic [INS_ADDR_W-1:0] ins_addr_t;

endpackage

`default_nettype wire

/* hw/ap_mem_pkg.sv */
`default_nettype none

package ap_mem_pkg;

    // Cache geometry.
    localparam int BLOCK_WORDS = 16;
    localparam int BLOCK_IDX_W = 4;
    localparam int TAG_W       = ap_isa_pkg::INS_ADDR_W - BLOCK_IDX_W;
    localparam int AXIL_ADDR_W = 32;
    localparam int AXIL_DATA_W = 32;

    typedef logic [BLOCK_IDX_W-1:0] block_idx_t;
    typedef logic [TAG_W-1:0]       block_tag_t;
    localparam block_idx_t LAST_IDX = block_idx_t'(BLOCK_WORDS - 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI4-Lite read channels.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;   // Byte address.
    typedef logic [AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [1:0]             axil_resp_t;
    localparam axil_resp_t RESP_OKAY = 2'b00;

    typedef struct packed {
        logic       arvalid;
        axil_addr_t araddr;
    } axil_ar_t;

    typedef struct packed {
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_r_t;

    // Cache to refill engine and back.
    typedef struct packed {
        logic                  valid;
        ap_isa_pkg::ins_addr_t base;
    } refill_req_t;

    typedef struct packed {
        logic             valid;
        block_idx_t       idx;
        ap_isa_pkg::ins_t ins;
        logic             err;
    } refill_wr_t;

    typedef enum logic [1:0] {IDLE, LOOKUP, REFILL} cache_state_e;

endpackage

`default_nettype wire

/* hw/ins_cache.sv */
`default_nettype none

module ins_cache (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          fetch_valid,
    input  wire ap_isa_pkg::ins_addr_t   fetch_addr,
    output logic                         fetch_done,
    output ap_isa_pkg::ins_t             fetch_ins,
    output logic                         fetch_err,
    output ap_mem_pkg::refill_req_t      refill_req,
    input  wire ap_mem_pkg::refill_wr_t  refill_wr,
    input  wire                          refill_done,
    input  wire                          refill_err,
    output logic [9:0]                   refill_count
);

    ap_mem_pkg::cache_state_e state;
    ap_isa_pkg::ins_t         block_mem [ap_mem_pkg::BLOCK_WORDS];
    ap_mem_pkg::block_tag_t   tag;
    logic                     tag_valid;
    logic                     refill_failed;     // Last refill came back with an error.
    logic                     hit;
    ap_mem_pkg::block_tag_t   fetch_tag;
    ap_mem_pkg::block_idx_t   fetch_idx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign fetch_tag = fetch_addr[ap_isa_pkg::INS_ADDR_W-1:ap_mem_pkg::BLOCK_IDX_W];
    assign fetch_idx = fetch_addr[ap_mem_pkg::BLOCK_IDX_W-1:0];
    assign hit       = tag_valid && (tag == fetch_tag);

    // Answer given in LOOKUP, one cycle after the request is taken.
    assign fetch_done = (state == ap_mem_pkg::LOOKUP) && (hit || refill_failed);
    assign fetch_err  = refill_failed;
    assign fetch_ins  = block_mem[fetch_idx];

    // One-cycle pulse, state leaves LOOKUP right after.
    assign refill_req.valid = (state == ap_mem_pkg::LOOKUP) && !hit && !refill_failed;
    assign refill_req.base  = {fetch_tag, {ap_mem_pkg::BLOCK_IDX_W{1'b0}}};

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state         <= ap_mem_pkg::IDLE;
            tag_valid     <= 1'b0;
            refill_failed <= 1'b0;
            refill_count  <= '0;
        end
        else
        begin
            case (state)
                ap_mem_pkg::IDLE:
                begin
                    if (fetch_valid)
                        state <= ap_mem_pkg::LOOKUP;
                end
                ap_mem_pkg::LOOKUP:
                begin
                    refill_failed <= 1'b0;
                    if (hit || refill_failed)
                        state <= ap_mem_pkg::IDLE;
                    else
                    begin
                        state     <= ap_mem_pkg::REFILL;
                        tag_valid <= 1'b0;      // Block is about to be overwritten.
                    end
                end
                ap_mem_pkg::REFILL:
                begin
                    if (refill_done)
                    begin
                        state         <= ap_mem_pkg::LOOKUP;   // Retry the waiting fetch.
                        refill_failed <= refill_err;
                        if (!refill_err)
                        begin
                            tag_valid    <= 1'b1;
                            refill_count <= refill_count + 10'd1;
                        end
                    end
                end
                default: state <= ap_mem_pkg::IDLE;
            endcase
        end
    end

    // Tag follows the block being loaded.
    always_ff @(posedge clk)
    begin
        if (refill_req.valid)
            tag <= fetch_tag;
    end

    // Storage array, poisoned words are dropped.
    always_ff @(posedge clk)
    begin
        if (refill_wr.valid && !refill_wr.err)
            block_mem[refill_wr.idx] <= refill_wr.ins;
    end

    a_wr_in_refill: assert property (@(posedge clk) disable iff (!rst)
        refill_wr.valid |-> state == ap_mem_pkg::REFILL);

endmodule

`default_nettype wire

/* hw/ins_fetch_seq.sv */
`default_nettype none

module ins_fetch_seq (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        start,
    input  wire ap_isa_pkg::ins_addr_t start_pc,
    output logic                       fetch_valid,
    output ap_isa_pkg::ins_addr_t      fetch_addr,
    input  wire                        fetch_done,
    input  wire ap_isa_pkg::ins_t      fetch_ins,
    input  wire                        fetch_err,
    output ap_isa_pkg::ins_t           ins_out,
    output logic                       ins_out_valid,
    input  wire                        ins_out_ready,
    output logic                       busy,
    output logic                       done,
    output logic                       fetch_error
);

    typedef enum logic [1:0] {IDLE, FETCH, EMIT, HALT} seq_state_e;

    seq_state_e            state;
    ap_isa_pkg::ins_addr_t pc;

    // Request held for the whole of FETCH, so fetch_addr stays put.
    assign fetch_valid   = (state == FETCH);
    assign fetch_addr    = pc;
    assign ins_out_valid = (state == EMIT);
    assign busy          = (state == FETCH) || (state == EMIT);
    assign fetch_error   = (state == HALT);     // Cleared by the next start.

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= IDLE;
            pc    <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                IDLE, HALT:
                begin
                    if (start)
                    begin
                        pc    <= start_pc;
                        state <= FETCH;
                    end
                end
                FETCH:
                begin
                    if (fetch_done)
                        state <= fetch_err ? HALT : EMIT;
                end
                EMIT:
                begin
                    if (ins_out_ready)
                    begin
                        if (ins_out.op == ap_isa_pkg::RET)
                        begin
                            state <= IDLE;
                            done  <= 1'b1;
                        end
                        else
                        begin
                            pc    <= pc + 16'd1;
                            state <= FETCH;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Output register.
    always_ff @(posedge clk)
    begin
        if (state == FETCH && fetch_done)
            ins_out <= fetch_ins;
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst)
        ins_out_valid && !ins_out_ready |=> ins_out_valid && $stable(ins_out));

endmodule

`default_nettype wire

/* hw/ins_fetch_top.sv */
`default_nettype none

module ins_fetch_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        start,
    input  wire ap_isa_pkg::ins_addr_t start_pc,
    output ap_isa_pkg::ins_t           ins_out,
    output logic                       ins_out_valid,
    input  wire                        ins_out_ready,
    output logic                       busy,
    output logic                       done,
    output logic                       fetch_error,
    output logic [9:0]                 refill_count,
    output ap_mem_pkg::axil_ar_t       ar,
    input  wire                        arready,
    input  wire ap_mem_pkg::axil_r_t   r,
    output logic                       rready
);

    // Sequencer to cache.
    logic                    fetch_valid;
    ap_isa_pkg::ins_addr_t   fetch_addr;
    logic                    fetch_done;
    ap_isa_pkg::ins_t        fetch_ins;
    logic                    fetch_err;

    // Cache to refill engine.
    ap_mem_pkg::refill_req_t refill_req;
    ap_mem_pkg::refill_wr_t  refill_wr;
    logic                    refill_done;
    logic                    refill_err;

    ins_fetch_seq u_seq (
        .clk, .rst, .start, .start_pc,
        .fetch_valid, .fetch_addr, .fetch_done, .fetch_ins, .fetch_err,
        .ins_out, .ins_out_valid, .ins_out_ready,
        .busy, .done, .fetch_error
    );

    ins_cache u_cache (
        .clk, .rst,
        .fetch_valid, .fetch_addr, .fetch_done, .fetch_ins, .fetch_err,
        .refill_req, .refill_wr, .refill_done, .refill_err,
        .refill_count
    );

    isa_axil_reader u_reader (
        .clk, .rst,
        .refill_req, .refill_wr, .refill_done, .refill_err,
        .ar, .arready, .r, .rready
    );

endmodule

`default_nettype wire

/* hw/isa_axil_reader.sv */
`default_nettype none

module isa_axil_reader (
    input  wire                          clk,
    input  wire                          rst,
    input  wire ap_mem_pkg::refill_req_t refill_req,
    output ap_mem_pkg::refill_wr_t       refill_wr,
    output logic                         refill_done,
    output logic                         refill_err,
    output ap_mem_pkg::axil_ar_t         ar,
    input  wire                          arready,
    input  wire ap_mem_pkg::axil_r_t     r,
    output logic                         rready
);

    typedef enum logic [1:0] {IDLE, ADDR, DATA} rd_state_e;

    rd_state_e              state;
    ap_mem_pkg::block_tag_t base_tag;
    ap_mem_pkg::block_idx_t word_idx;
    ap_isa_pkg::ins_addr_t  word_addr;
    logic                   word_err;
    logic                   err_acc;
    logic                   wr_valid;
    ap_mem_pkg::block_idx_t wr_idx;
    ap_isa_pkg::ins_t       wr_ins;
    logic                   wr_err;

    assign word_addr  = {base_tag, word_idx};
    assign ar.arvalid = (state == ADDR);
    assign ar.araddr  = {{(ap_mem_pkg::AXIL_ADDR_W - ap_isa_pkg::INS_ADDR_W - 2){1'b0}},
                         word_addr, 2'b00};    // Word to byte address.
    assign rready     = (state == DATA);
    assign word_err   = (r.rresp != ap_mem_pkg::RESP_OKAY);
    assign refill_wr  = '{valid: wr_valid, idx: wr_idx, ins: wr_ins, err: wr_err};
    assign refill_err = err_acc;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state       <= IDLE;
            word_idx    <= '0;
            err_acc     <= 1'b0;
            wr_valid    <= 1'b0;
            refill_done <= 1'b0;
        end
        else
        begin
            wr_valid    <= 1'b0;
            refill_done <= wr_valid && (wr_idx == ap_mem_pkg::LAST_IDX);  // After word 15.
            case (state)
                IDLE:
                begin
                    if (refill_req.valid)
                    begin
                        word_idx <= '0;
                        err_acc  <= 1'b0;
                        state    <= ADDR;
                    end
                end
                ADDR:
                begin
                    if (arready)
                        state <= DATA;
                end
                DATA:
                begin
                    if (r.rvalid)
                    begin
                        wr_valid <= 1'b1;
                        err_acc  <= err_acc | word_err;
                        word_idx <= word_idx + 4'd1;
                        state    <= (word_idx == ap_mem_pkg::LAST_IDX) ? IDLE : ADDR;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && refill_req.valid)
            base_tag <= refill_req.base[ap_isa_pkg::INS_ADDR_W-1:ap_mem_pkg::BLOCK_IDX_W];
        if (state == DATA && r.rvalid)
        begin
            wr_idx <= word_idx;
            wr_ins <= ap_isa_pkg::ins_t'(r.rdata[ap_isa_pkg::INS_W-1:0]);
            wr_err <= word_err;
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst)
        ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr));

endmodule

`default_nettype wire

/* verification/tb_axil_mem.sv */
`default_nettype none

module tb_axil_mem (
    input  wire                        clk,
    input  wire                        rst,
    input  wire ap_mem_pkg::axil_ar_t  ar,
    output logic                       arready,
    output ap_mem_pkg::axil_r_t        r,
    input  wire                        rready,
    input  wire [1:0]                  latency,
    input  wire                        err_en,
    input  wire ap_isa_pkg::ins_addr_t err_addr,
    output int                         addr_errors
);

    ap_isa_pkg::ins_t       image [256];    // Program image, word addressed.
    logic                   ar_fire;
    logic                   r_fire;
    ap_mem_pkg::axil_addr_t ar_addr;
    logic [1:0]             ar_lat;
    logic                   pending;
    logic [1:0]             wait_cnt;
    ap_mem_pkg::axil_addr_t next_addr;
    logic                   in_block;       // Inside a block, next AR must follow on.

    initial
    begin
        arready     = 1'b0;
        r           = '0;
        addr_errors = 0;
        pending     = 1'b0;
        in_block    = 1'b0;
    end

    // Handshakes seen at the rising edge.
    always @(posedge clk)
    begin
        ar_fire <= ar.arvalid && arready;
        r_fire  <= r.rvalid && rready;
        if (ar.arvalid && arready)
        begin
            ar_addr <= ar.araddr;
            ar_lat  <= latency;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Channel outputs change on the falling edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk)
    begin
        if (!rst)
        begin
            arready  = 1'b0;
            r        = '0;
            pending  = 1'b0;
            in_block = 1'b0;
        end
        else
        begin
            if (r_fire)
            begin
                r.rvalid = 1'b0;
                pending  = 1'b0;
            end
            if (ar_fire)
            begin
                if ((in_block && ar_addr != next_addr) || (!in_block && ar_addr[5:0] != 6'd0))
                begin
                    $display("ERROR at %0t: AR address %h out of order", $time, ar_addr);
                    addr_errors = addr_errors + 1;
                end
                next_addr = ar_addr + 32'd4;
                in_block  = (ar_addr[5:2] != 4'hF);   // Word 15 closes the block.
                pending   = 1'b1;
                wait_cnt  = ar_lat;
            end
            if (pending && !r.rvalid)
            begin
                if (wait_cnt == 2'd0)
                begin
                    r.rvalid = 1'b1;
                    r.rdata  = {2'b10, image[ar_addr[9:2]]};   // Top bits are noise.
                    r.rresp  = (err_en && ar_addr[17:2] == err_addr) ? 2'b10 : 2'b00;
                end
                else
                    wait_cnt = wait_cnt - 2'd1;
            end
            arready = !pending;     // One read at a time.
        end
    end

endmodule

`default_nettype wire

/* verification/tb_ins_fetch.sv */
`default_nettype none

module tb_ins_fetch;

    localparam int RUNS        = 4;
    localparam int CYCLE_LIMIT = RUNS * 64 * (16 * 6 + 8);

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  start;
    ap_isa_pkg::ins_addr_t start_pc;
    ap_isa_pkg::ins_t      ins_out;
    logic                  ins_out_valid;
    logic                  ins_out_ready;
    logic                  busy;
    logic                  done;
    logic                  fetch_error;
    logic [9:0]            refill_count;
    ap_mem_pkg::axil_ar_t  ar;
    logic                  arready;
    ap_mem_pkg::axil_r_t   r;
    logic                  rready;
    logic [1:0]            latency;
    logic                  err_en;
    ap_isa_pkg::ins_addr_t err_addr;
    int                    addr_errors;

    logic [15:0]           lfsr;
    int                    err_cnt;
    int                    cycles;
    int                    cached_blk;      // -1 when no valid block.
    ap_isa_pkg::ins_t      exp_q [$];
    logic                  stalled;
    ap_isa_pkg::ins_t      held_ins;

    ins_fetch_top u_ins_fetch_top (
        .clk, .rst, .start, .start_pc,
        .ins_out, .ins_out_valid, .ins_out_ready,
        .busy, .done, .fetch_error, .refill_count,
        .ar, .arready, .r, .rready
    );

    tb_axil_mem u_mem (
        .clk, .rst, .ar, .arready, .r, .rready,
        .latency, .err_en, .err_addr, .addr_errors
    );

    initial
    begin
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random source and checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic next_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 16'hB400;
        return b;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], next_bit()};
        return v;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            err_cnt = err_cnt + 1;
        end
    endtask

    // Random fields, no RET except at the chosen ends.
    task automatic build_image();
        logic [3:0] op;
        for (int a = 0; a < 256; a++)
        begin
            op = 4'(random_bits(4));
            if (op == 4'd2)
                op = 4'd3;
            u_mem.image[a] = ap_isa_pkg::ins_t'({op, 8'(random_bits(8)), 2'(random_bits(2)),
                                                 8'(random_bits(8)), 8'(a)});
        end
        u_mem.image[40].op  = ap_isa_pkg::RET;
        u_mem.image[110].op = ap_isa_pkg::RET;
        u_mem.image[150].op = ap_isa_pkg::RET;
    endtask

    // Expected stream into exp_q, returns the refills of the run.
    function automatic int predict_run(input ap_isa_pkg::ins_addr_t pc0, output logic exp_err);
        ap_isa_pkg::ins_addr_t pc;
        ap_isa_pkg::ins_t      ins;
        int                    blk;
        int                    refills;
        logic                  stop;
        pc      = pc0;
        blk     = cached_blk;
        refills = 0;
        exp_err = 1'b0;
        stop    = 1'b0;
        exp_q.delete();
        while (!stop)
        begin
            if (int'(pc[15:4]) != blk)
            begin
                if (err_en && err_addr[15:4] == pc[15:4])
                begin
                    exp_err = 1'b1;
                    stop    = 1'b1;
                    blk     = -1;
                end
                else
                begin
                    refills = refills + 1;
                    blk     = int'(pc[15:4]);
                end
            end
            if (!stop)
            begin
                ins = u_mem.image[pc[7:0]];
                exp_q.push_back(ins);
                stop = (ins.op == ap_isa_pkg::RET);
                pc   = pc + 16'd1;
            end
        end
        cached_blk = blk;
        return refills;
    endfunction

    task automatic run_program(input ap_isa_pkg::ins_addr_t pc0);
        logic [9:0] base_count;
        int         exp_refills;
        logic       exp_err;
        base_count  = refill_count;
        exp_refills = predict_run(pc0, exp_err);
        start    = 1'b1;
        start_pc = pc0;
        @(negedge clk);
        start = 1'b0;
        check_value(32'(busy), 32'd1, "busy after start");
        while (!done && !fetch_error)
            @(negedge clk);
        check_value(32'(fetch_error), 32'(exp_err), "fetch_error");
        check_value(32'(busy), 32'd0, "busy at end of run");
        check_value(32'(exp_q.size()), 32'd0, "instructions not delivered");
        check_value(32'(refill_count - base_count), 32'(exp_refills), "refills in run");
        @(negedge clk);
        check_value(32'(done), 32'd0, "done one cycle later");
        if (exp_err)
        begin
            repeat (20)
            begin
                @(negedge clk);
                check_value(32'(ins_out_valid), 32'd0, "ins_out_valid after error");
            end
        end
    endtask

    // Random ready and read latency.
    always @(negedge clk)
    begin
        ins_out_ready = (random_bits(2) != 32'd0);
        latency       = 2'(random_bits(2));
    end

    // Compare process.
    always @(posedge clk)
    begin
        if (rst)
        begin
            if (stalled)
            begin
                check_value(32'(ins_out_valid), 32'd1, "ins_out_valid under stall");
                check_value(32'(ins_out), 32'(held_ins), "ins_out under stall");
            end
            if (ins_out_valid && ins_out_ready)
            begin
                check_value(32'(exp_q.size() != 0), 32'd1, "instruction left in reference");
                if (exp_q.size() != 0)
                    check_value(32'(ins_out), 32'(exp_q.pop_front()), "ins_out");
            end
        end
        stalled  = ins_out_valid && !ins_out_ready;
        held_ins = ins_out;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles == CYCLE_LIMIT)
        begin
            $display("Timeout: runs not finished within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        lfsr          = 16'd41619;
        err_cnt       = 0;
        cycles        = 0;
        cached_blk    = -1;
        stalled       = 1'b0;
        rst           = 1'b0;
        start         = 1'b0;
        start_pc      = '0;
        ins_out_ready = 1'b0;
        latency       = 2'd0;
        err_en        = 1'b0;
        err_addr      = 16'd100;     // Inside block 6.
        build_image();
        repeat (8) @(negedge clk);
        check_value(32'(busy), 32'd0, "busy in reset");
        check_value(32'(done), 32'd0, "done in reset");
        check_value(32'(fetch_error), 32'd0, "fetch_error in reset");
        check_value(32'(ins_out_valid), 32'd0, "ins_out_valid in reset");
        check_value(32'(ar.arvalid), 32'd0, "arvalid in reset");
        check_value(32'(rready), 32'd0, "rready in reset");
        check_value(32'(refill_count), 32'd0, "refill_count in reset");
        rst = 1'b1;
        @(negedge clk);
        run_program(16'd5);      // Crosses blocks 0 to 2.
        run_program(16'd34);     // Stays in the cached block.
        err_en = 1'b1;
        run_program(16'd70);
        run_program(16'd130);
        $display("Errors: %0d in checks, %0d in AXI address order", err_cnt, addr_errors);
        if (err_cnt == 0 && addr_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
